// ==== project.f ====
hdl/sensor_udp_pkg.sv
hdl/stream_reg.sv
hdl/payload_builder.sv
hdl/frame_sequencer.sv
hdl/status_display.sv
hdl/sensor_udp_core.sv
bench/sensor_udp_tb.sv

// ==== bench/sensor_udp_tb.sv ====
// Testbench for the sample to UDP datagram block
// Table driven samples, random output back-pressure, header, payload and status checks

`timescale 1ns/1ps

module sensor_udp_tb import sensor_udp_pkg::*;;

    localparam int          TABLE_LEN  = 8;
    localparam logic [31:0] LOCAL_IP   = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [31:0] DEST_IP    = {8'd192, 8'd168, 8'd1, 8'd100};
    localparam logic [15:0] SRC_PORT   = 16'd1234;
    localparam logic [15:0] DST_PORT   = 16'd5678;
    localparam logic [31:0] SEED       = 32'heeb6_1af6;

    typedef struct packed {
        logic [15:0] n;
        logic [15:0] m;
        logic [15:0] adc_data;
        logic        send;         // send_enable level
        logic        bp_random;    // Random hdr_ready / beat_ready
    } stim_t;

    // n, m, adc_data, send_enable, random back-pressure
    localparam stim_t STIM [TABLE_LEN] = '{
        '{16'h1234, 16'h5678, 16'h9ABC, 1'b1, 1'b0},
        '{16'hA5C3, 16'h0001, 16'hFFFF, 1'b1, 1'b0},
        '{16'hDEAD, 16'hBEEF, 16'h0BAD, 1'b0, 1'b0},   // dropped
        '{16'h7F80, 16'h00FF, 16'h8001, 1'b1, 1'b1},
        '{16'h0000, 16'h0000, 16'h0000, 1'b1, 1'b1},
        '{16'hC0DE, 16'hFACE, 16'h1357, 1'b0, 1'b1},   // dropped under back-pressure
        '{16'h3C4B, 16'h2468, 16'hACE0, 1'b1, 1'b1},
        '{16'hFEDC, 16'hBA98, 16'h7654, 1'b1, 1'b0}
    };

    // Seven-segment codes with bit 0 = a and high = lit
    localparam logic [6:0] SEG_LIT [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic clk;
    logic rst;
    logic send_enable;
    sample_t sample;
    logic sample_valid;
    logic sample_ready;
    udp_hdr_t hdr;
    logic hdr_valid;
    logic hdr_ready;
    payload_beat_t beat;
    logic beat_valid;
    logic beat_ready;
    logic [7:0] ledg;
    logic [SEG_DIGITS-1:0][6:0] hex;

    logic bp_random;               // Ready mode for the current entry
    logic [7:0] last_ledg;
    udp_hdr_t hdr_q[$];            // Recorded output transfers
    payload_beat_t beat_q[$];
    logic hdr_stalled;
    logic beat_stalled;
    udp_hdr_t hdr_held;
    payload_beat_t beat_held;

    sensor_udp_core #(
        .LOCAL_IP   (LOCAL_IP),
        .DEST_IP    (DEST_IP),
        .SRC_PORT   (SRC_PORT),
        .DST_PORT   (DST_PORT),
        .SEG_INVERT (1'b1)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .send_enable  (send_enable),
        .sample       (sample),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .hdr          (hdr),
        .hdr_valid    (hdr_valid),
        .hdr_ready    (hdr_ready),
        .beat         (beat),
        .beat_valid   (beat_valid),
        .beat_ready   (beat_ready),
        .ledg         (ledg),
        .hex          (hex)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;     // 8 ns period
    end

    task automatic report_value(input string name, input logic [143:0] got,
                                input logic [143:0] exp);
        $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        $display("Simulation FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "check failed");
    endtask

    // Payload byte idx of a sample is the three words MSB first and then the tag run
    function automatic logic [7:0] expected_byte(input stim_t s, input int idx);
        case (idx)
            0: return s.n[15:8];
            1: return s.n[7:0];
            2: return s.m[15:8];
            3: return s.m[7:0];
            4: return s.adc_data[15:8];
            5: return s.adc_data[7:0];
            default: return 8'h47 + 8'(idx - 6);
        endcase
    endfunction

    // Active-low digits with digit k showing nibble k
    function automatic logic [SEG_DIGITS-1:0][6:0] expected_hex(input logic [31:0] ip);
        logic [SEG_DIGITS-1:0][6:0] r;
        for (int k = 0; k < SEG_DIGITS; k++)
            r[k] = ~SEG_LIT[ip[4*k +: 4]];
        return r;
    endfunction

    // Output side monitor that sets ready and records transfers on the falling edge
    always @(negedge clk) begin
        if (rst) begin
            hdr_stalled  = 1'b0;
            beat_stalled = 1'b0;
        end else begin
            if (hdr_stalled) begin
                assert (hdr_valid) else report_failure("hdr_valid dropped while stalled");
                assert (hdr === hdr_held) else report_value("hdr", hdr, hdr_held);
            end
            if (beat_stalled) begin
                assert (beat_valid) else report_failure("beat_valid dropped while stalled");
                assert (beat === beat_held) else report_value("beat", beat, beat_held);
            end
            hdr_ready  = bp_random ? (($urandom() % 4) != 0) : 1'b1;
            beat_ready = bp_random ? (($urandom() % 3) != 0) : 1'b1;
            if (hdr_valid && hdr_ready)
                hdr_q.push_back(hdr);      // Transfers on the next rising edge
            if (beat_valid && beat_ready)
                beat_q.push_back(beat);
            hdr_stalled  = hdr_valid && !hdr_ready;
            beat_stalled = beat_valid && !beat_ready;
            hdr_held     = hdr;
            beat_held    = beat;
        end
    end

    task automatic wait_frame();
        @(posedge clk);
        while (hdr_q.size() == 0 || beat_q.size() == 0 || !beat_q[$].last)
            @(posedge clk);
        @(negedge clk);                    // Last transfers and status settled
    endtask

    task automatic check_frame(input stim_t s);
        udp_hdr_t exp_hdr;
        exp_hdr = '{ip_dscp: 6'd0, ip_ecn: 2'd0, ip_ttl: 8'd64, source_ip: LOCAL_IP,
                    dest_ip: DEST_IP, source_port: SRC_PORT, dest_port: DST_PORT,
                    length: 16'd26, checksum: 16'd0};
        assert (hdr_q.size() == 1) else report_value("header count", hdr_q.size(), 1);
        assert (hdr_q[0] === exp_hdr) else report_value("hdr", hdr_q[0], exp_hdr);
        assert (beat_q.size() == PAYLOAD_BYTES)
            else report_value("beat count", beat_q.size(), PAYLOAD_BYTES);
        for (int k = 0; k < PAYLOAD_BYTES; k++) begin
            assert (beat_q[k].data === expected_byte(s, k))
                else report_value("beat.data", beat_q[k].data, expected_byte(s, k));
            assert (beat_q[k].last === (k == PAYLOAD_BYTES - 1))
                else report_value("beat.last", beat_q[k].last, k == PAYLOAD_BYTES - 1);
        end
        assert (ledg === s.n[15:8]) else report_value("ledg", ledg, s.n[15:8]);
        assert (hex === expected_hex(DEST_IP))
            else report_value("hex", hex, expected_hex(DEST_IP));
        last_ledg = s.n[15:8];
        hdr_q.delete();
        beat_q.delete();
    endtask

    task automatic run_entry(input stim_t s);
        @(negedge clk);
        bp_random    = s.bp_random;
        send_enable  = s.send;
        sample       = '{n: s.n, m: s.m, adc_data: s.adc_data};
        sample_valid = 1'b1;
        while (!sample_ready)
            @(negedge clk);
        @(negedge clk);                    // Taken on the edge just passed
        sample_valid = 1'b0;
        sample       = ~sample;            // Payload must come from the captured copy
        if (s.send) begin
            assert (!sample_ready) else report_value("sample_ready", sample_ready, 1'b0);
            wait_frame();
            check_frame(s);
        end else begin
            repeat (12) @(negedge clk);    // Long enough for a frame to start
            assert (hdr_q.size() == 0 && beat_q.size() == 0)
                else report_failure("Dropped sample produced header or payload output");
            assert (sample_ready) else report_value("sample_ready", sample_ready, 1'b1);
            assert (ledg === last_ledg) else report_value("ledg", ledg, last_ledg);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst          = 1'b1;
        send_enable  = 1'b0;
        sample       = '0;
        sample_valid = 1'b0;
        hdr_ready    = 1'b0;
        beat_ready   = 1'b0;
        bp_random    = 1'b0;
        last_ledg    = 8'h00;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Reset state
        assert (!sample_ready) else report_value("sample_ready", sample_ready, 1'b0);
        assert (!hdr_valid) else report_value("hdr_valid", hdr_valid, 1'b0);
        assert (!beat_valid) else report_value("beat_valid", beat_valid, 1'b0);
        assert (ledg === 8'h00) else report_value("ledg", ledg, 8'h00);
        assert (hex === expected_hex(32'h0)) else report_value("hex", hex, expected_hex(32'h0));
        for (int i = 0; i < TABLE_LEN; i++)
            run_entry(STIM[i]);
        @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

    // Watchdog bound of 200 cycles per table entry
    initial begin
        repeat (TABLE_LEN * 200) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TABLE_LEN * 200);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== hdl/sensor_udp_core.sv ====
// Top level of the sample to UDP datagram block
// Wires the sequencer, payload mux, output registers and status display

`timescale 1ns/1ps

module sensor_udp_core import sensor_udp_pkg::*; #(
    parameter logic [31:0] LOCAL_IP   = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter logic [31:0] DEST_IP    = {8'd192, 8'd168, 8'd1, 8'd100},
    parameter logic [15:0] SRC_PORT   = 16'd1234,
    parameter logic [15:0] DST_PORT   = 16'd5678,
    parameter bit          SEG_INVERT = 1'b1   // Active-low segments
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          send_enable,   // Drop samples when low
    // ADC sample stream
    input  sample_t                       sample,
    input  logic                          sample_valid,
    output logic                          sample_ready,
    // UDP header to the stack
    output udp_hdr_t                      hdr,
    output logic                          hdr_valid,
    input  logic                          hdr_ready,
    // UDP payload bytes to the stack
    output payload_beat_t                 beat,
    output logic                          beat_valid,
    input  logic                          beat_ready,
    // Board status
    output logic [7:0]                    ledg,
    output logic [SEG_DIGITS-1:0][6:0]    hex
);

    // Sequencer to output registers
    udp_hdr_t      hdr_in;
    logic          hdr_in_valid;
    logic          hdr_in_ready;
    payload_beat_t beat_in;
    logic          beat_in_valid;
    logic          beat_in_ready;

    // Sequencer to payload mux
    logic          capture;
    byte_idx_t     byte_idx;
    logic [7:0]    payload_byte;

    logic          hdr_fire;      // Output side transfers
    logic          beat_fire;

    assign hdr_fire  = hdr_valid && hdr_ready;
    assign beat_fire = beat_valid && beat_ready;

    frame_sequencer #(
        .LOCAL_IP (LOCAL_IP),
        .DEST_IP  (DEST_IP),
        .SRC_PORT (SRC_PORT),
        .DST_PORT (DST_PORT)
    ) u_frame_sequencer (
        .clk           (clk),
        .rst           (rst),
        .send_enable   (send_enable),
        .sample_valid  (sample_valid),
        .sample_ready  (sample_ready),
        .capture       (capture),
        .byte_idx      (byte_idx),
        .payload_byte  (payload_byte),
        .hdr_in        (hdr_in),
        .hdr_in_valid  (hdr_in_valid),
        .hdr_in_ready  (hdr_in_ready),
        .beat_in       (beat_in),
        .beat_in_valid (beat_in_valid),
        .beat_in_ready (beat_in_ready)
    );

    payload_builder u_payload_builder (
        .clk          (clk),
        .rst          (rst),
        .sample       (sample),
        .capture      (capture),
        .byte_idx     (byte_idx),
        .payload_byte (payload_byte)
    );

    stream_reg #(.T(udp_hdr_t)) u_hdr_reg (
        .clk       (clk),
        .rst       (rst),
        .in_data   (hdr_in),
        .in_valid  (hdr_in_valid),
        .in_ready  (hdr_in_ready),
        .out_data  (hdr),
        .out_valid (hdr_valid),
        .out_ready (hdr_ready)
    );

    stream_reg #(.T(payload_beat_t)) u_beat_reg (
        .clk       (clk),
        .rst       (rst),
        .in_data   (beat_in),
        .in_valid  (beat_in_valid),
        .in_ready  (beat_in_ready),
        .out_data  (beat),
        .out_valid (beat_valid),
        .out_ready (beat_ready)
    );

    status_display #(
        .SEG_INVERT (SEG_INVERT)
    ) u_status_display (
        .clk         (clk),
        .rst         (rst),
        .hdr_dest_ip (hdr.dest_ip),
        .hdr_fire    (hdr_fire),
        .beat        (beat),
        .beat_fire   (beat_fire),
        .ledg        (ledg),
        .hex         (hex)
    );

endmodule

// ==== hdl/status_display.sv ====
// Board status display
// First payload byte of each frame on the green LEDs, last destination IP
// as eight hex digits on the seven-segment displays

`timescale 1ns/1ps

module status_display import sensor_udp_pkg::*; #(
    parameter bit SEG_INVERT = 1'b1
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [31:0]                hdr_dest_ip,
    input  logic                       hdr_fire,
    input  payload_beat_t              beat,
    input  logic                       beat_fire,
    output logic [7:0]                 ledg,
    output logic [SEG_DIGITS-1:0][6:0] hex
);

    logic        in_frame;     // Past the first beat of the current frame
    logic [31:0] dest_ip_q;

    // Segment pattern, bit 0 = a through bit 6 = g, high = lit
    function automatic logic [6:0] seg7(input logic [3:0] nib);
        logic [6:0] seg;
        case (nib)
            4'h0: seg = 7'h3F;
            4'h1: seg = 7'h06;
            4'h2: seg = 7'h5B;
            4'h3: seg = 7'h4F;
            4'h4: seg = 7'h66;
            4'h5: seg = 7'h6D;
            4'h6: seg = 7'h7D;
            4'h7: seg = 7'h07;
            4'h8: seg = 7'h7F;
            4'h9: seg = 7'h6F;
            4'hA: seg = 7'h77;
            4'hB: seg = 7'h7C;     // lower case b
            4'hC: seg = 7'h39;
            4'hD: seg = 7'h5E;     // lower case d
            4'hE: seg = 7'h79;
            default: seg = 7'h71;  // F
        endcase
        return seg;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame  <= 1'b0;
            ledg      <= 8'h00;
            dest_ip_q <= 32'h0;
        end else begin
            if (hdr_fire)
                dest_ip_q <= hdr_dest_ip;
            if (beat_fire) begin
                if (!in_frame)
                    ledg <= beat.data;     // First byte only
                in_frame <= !beat.last;    // Re-arm after the last beat
            end
        end
    end

    // Digit k shows nibble k of the address
    for (genvar k = 0; k < SEG_DIGITS; k++) begin : g_digit
        assign hex[k] = SEG_INVERT ? ~seg7(dest_ip_q[4*k +: 4])
                                   :  seg7(dest_ip_q[4*k +: 4]);
    end

endmodule

// ==== hdl/frame_sequencer.sv ====
// Frame control FSM
// Accepts a sample, then issues one UDP header and 18 payload beats

`timescale 1ns/1ps

module frame_sequencer import sensor_udp_pkg::*; #(
    parameter logic [31:0] LOCAL_IP = 32'hC0A8_0180,
    parameter logic [31:0] DEST_IP  = 32'hC0A8_0164,
    parameter logic [15:0] SRC_PORT = 16'd1234,
    parameter logic [15:0] DST_PORT = 16'd5678
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          send_enable,
    input  logic          sample_valid,
    output logic          sample_ready,
    output logic          capture,         // Latch sample into payload mux
    output byte_idx_t     byte_idx,
    input  logic [7:0]    payload_byte,
    output udp_hdr_t      hdr_in,
    output logic          hdr_in_valid,
    input  logic          hdr_in_ready,
    output payload_beat_t beat_in,
    output logic          beat_in_valid,
    input  logic          beat_in_ready
);

    localparam byte_idx_t LAST_IDX = byte_idx_t'(PAYLOAD_BYTES - 1);

    typedef enum logic [1:0] {
        IDLE,       // waiting for a sample
        SEND,       // streaming payload beats
        DRAIN       // beats done, header still stalled
    } state_t;

    state_t state;
    logic   armed;          // Low through reset, high from the first cycle after
    logic   load;           // One cycle after capture
    logic   hdr_pend;       // Header offered, not yet taken
    logic   beat_pend;      // Beat offered, not yet taken

    logic   sample_fire;
    logic   hdr_push;
    logic   beat_push;
    logic   last_push;

    assign sample_ready = (state == IDLE) && armed;
    assign sample_fire  = sample_valid && sample_ready;
    assign capture      = sample_fire && send_enable;   // Disabled samples just vanish

    assign hdr_push  = hdr_in_valid && hdr_in_ready;
    assign beat_push = beat_in_valid && beat_in_ready;
    assign last_push = beat_push && beat_in.last;

    // Header is constant apart from the handshake
    assign hdr_in = '{
        ip_dscp:     6'd0,
        ip_ecn:      2'd0,
        ip_ttl:      8'(UDP_TTL),
        source_ip:   LOCAL_IP,
        dest_ip:     DEST_IP,
        source_port: SRC_PORT,
        dest_port:   DST_PORT,
        length:      16'(UDP_HDR_BYTES + PAYLOAD_BYTES),
        checksum:    16'd0
    };
    assign hdr_in_valid = hdr_pend;

    assign beat_in.data  = payload_byte;            // Mux output for current index
    assign beat_in.last  = (byte_idx == LAST_IDX);
    assign beat_in_valid = beat_pend;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            armed     <= 1'b0;
            load      <= 1'b0;
            hdr_pend  <= 1'b0;
            beat_pend <= 1'b0;
            byte_idx  <= '0;
        end else begin
            armed <= 1'b1;
            load  <= capture;

            if (hdr_push)
                hdr_pend <= 1'b0;

            if (beat_push) begin
                if (beat_in.last)
                    beat_pend <= 1'b0;
                else
                    byte_idx <= byte_idx + 1'b1;   // Next byte back to back
            end

            // Sampled payload is in the mux now so offer header and beat 0
            if (load) begin
                hdr_pend  <= 1'b1;
                beat_pend <= 1'b1;
            end

            case (state)
                IDLE: begin
                    if (capture) begin
                        state    <= SEND;
                        byte_idx <= '0;
                    end
                end
                SEND: begin
                    if (last_push)
                        state <= (hdr_pend && !hdr_push) ? DRAIN : IDLE;
                end
                DRAIN: begin
                    if (hdr_push)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Index stays inside the payload for the whole frame
    assert property (@(posedge clk) disable iff (rst) byte_idx <= LAST_IDX)
        else $error("byte_idx out of range: %0d", byte_idx);

endmodule

// ==== hdl/payload_builder.sv ====
// Payload byte mux
// Holds the captured sample and returns the payload byte for an index

`timescale 1ns/1ps

module payload_builder import sensor_udp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  sample_t    sample,
    input  logic       capture,        // Single-cycle latch strobe
    input  byte_idx_t  byte_idx,
    output logic [7:0] payload_byte
);

    sample_t sample_q;     // Frozen for the whole frame

    always_ff @(posedge clk) begin
        if (rst)
            sample_q <= '0;
        else if (capture)
            sample_q <= sample;
    end

    // Sample words first, then the fixed tag run
    always_comb begin
        if (byte_idx < byte_idx_t'(SAMPLE_BYTES))
            payload_byte = sample_byte(sample_q, byte_idx);
        else
            payload_byte = tag_byte(byte_idx);
    end

endmodule

// ==== hdl/stream_reg.sv ====
// One-entry valid/ready pipeline register
// Ready passes through from the output, so a full register still takes
// one item per cycle

`timescale 1ns/1ps

module stream_reg #(
    parameter type T = logic [7:0]
) (
    input  logic clk,
    input  logic rst,
    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,
    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    T     data_q;
    logic valid_q;

    assign in_ready  = !valid_q || out_ready;   // Empty, or draining this cycle
    assign out_data  = data_q;
    assign out_valid = valid_q;

    always_ff @(posedge clk) begin
        if (rst)
            valid_q <= 1'b0;
        else if (in_ready)
            valid_q <= in_valid;
    end

    // Payload register, loads only on an input transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            data_q <= in_data;
    end

    // Stalled item holds until the consumer takes it
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("stream_reg output changed while stalled");

endmodule

// ==== hdl/sensor_udp_pkg.sv ====
// Shared types and constants for the ADC sample to UDP datagram path
// Sample, header and payload beat structs plus the payload layout rules

package sensor_udp_pkg;

    // Payload layout
    localparam int PAYLOAD_BYTES = 18;      // 6 sample bytes + 12 tag bytes
    localparam int SAMPLE_BYTES  = 6;       // n, m, adc_data
    localparam int UDP_HDR_BYTES = 8;
    localparam int UDP_TTL       = 64;
    localparam logic [7:0] TAG_FIRST = 8'h47;

    // Status display
    localparam int SEG_DIGITS = 8;          // one digit per dest IP nibble

    typedef logic [4:0] byte_idx_t;         // covers 0..PAYLOAD_BYTES-1

    // One ADC capture, three 16-bit words
    typedef struct packed {
        logic [15:0] n;
        logic [15:0] m;
        logic [15:0] adc_data;
    } sample_t;

    // UDP header fields handed to the IP stack
    typedef struct packed {
        logic [5:0]  ip_dscp;
        logic [1:0]  ip_ecn;
        logic [7:0]  ip_ttl;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;               // UDP header + payload bytes
        logic [15:0] checksum;             // 0, not computed
    } udp_hdr_t;

    // Payload byte stream element
    typedef struct packed {
        logic [7:0] data;
        logic       last;                  // High on the final payload byte
    } payload_beat_t;

    // Fixed tag byte for payload index idx, valid for idx >= SAMPLE_BYTES
    function automatic logic [7:0] tag_byte(input byte_idx_t idx);
        logic [7:0] offset;
        offset = 8'(idx) - 8'(SAMPLE_BYTES);
        return TAG_FIRST + offset;
    endfunction

    // Sample byte for index idx < SAMPLE_BYTES, MSB of each word first
    function automatic logic [7:0] sample_byte(input sample_t s, input byte_idx_t idx);
        logic [47:0] flat;
        flat = s;                          // n in the top bits
        return flat[47 - 8 * idx -: 8];
    endfunction

endpackage
